/* Bender.yml */
package:
  name: simd_exec_unit

sources:
  - rtl/simd_pkg.sv
  - rtl/operand_forward.sv
  - rtl/issue_stage.sv
  - rtl/simd_int_alu.sv
  - rtl/simd_cmp.sv
  - rtl/result_writeback.sv
  - rtl/simd_exec_unit.sv
  - target: test
    files:
      - tb/simd_exec_unit_asserts.sv
      - tb/tb_simd_exec_unit.sv

/* rtl/issue_stage.sv */
/*
  Issue stage
  classifies the opcode and registers decoded control with both operands
*/
`timescale 1ns/1ps
`default_nettype none

module issue_stage (
  input  wire              clk,
  input  wire              rst,
  input  simd_pkg::issue_t issue,
  input  simd_pkg::word_t  fwd_a,
  input  simd_pkg::word_t  fwd_b,
  output simd_pkg::dec_t   dec,
  output simd_pkg::word_t  op_a,
  output simd_pkg::word_t  op_b
);

  logic is_cmp;

  // compares go to the mask lane, everything else to the integer lane
  assign is_cmp = (issue.op == simd_pkg::OP_CMPEQ) ||
                  (issue.op == simd_pkg::OP_CMPGT);

  always_ff @(posedge clk) begin
    if (rst) begin
      dec <= '0;
    end else begin
      dec.valid <= issue.valid;
      if (issue.valid) begin
        dec.is_cmp <= is_cmp;
        dec.op     <= issue.op;
        dec.size   <= issue.size;
      end
    end
  end

  // operands hold between issues
  always_ff @(posedge clk) begin
    if (issue.valid) begin
      op_a <= fwd_a;
      op_b <= fwd_b;
    end
  end

endmodule

`default_nettype wire

/* rtl/operand_forward.sv */
/*
  Operand bypass mux
  picks register value, own result or an external bus, current or one cycle late
*/
`timescale 1ns/1ps
`default_nettype none

module operand_forward #(
  parameter int NUM_EXT_FWD = 2
) (
  input  wire                clk,
  input  wire                rst,
  input  simd_pkg::fwd_sel_t sel,
  input  simd_pkg::word_t    reg_val,
  input  simd_pkg::word_t    self_bus,
  input  simd_pkg::word_t    ext_bus [NUM_EXT_FWD],
  output simd_pkg::word_t    operand
);

  simd_pkg::word_t self_late;
  simd_pkg::word_t ext_late [NUM_EXT_FWD];
  int              ext_num;

  // late copies track every bus each edge
  always_ff @(posedge clk) begin
    if (rst) begin
      self_late <= '0;
      for (int i = 0; i < NUM_EXT_FWD; i++) ext_late[i] <= '0;
    end else begin
      self_late <= self_bus;
      for (int i = 0; i < NUM_EXT_FWD; i++) ext_late[i] <= ext_bus[i];
    end
  end

  assign ext_num = (sel.src == simd_pkg::SRC_EXT1) ? 1 : 0;

  always_comb begin
    operand = '0;
    case (sel.src)
      simd_pkg::SRC_REG:  operand = reg_val;
      simd_pkg::SRC_SELF: operand = sel.late ? self_late : self_bus;
      default: begin
        // bus numbers past NUM_EXT_FWD stay zero
        for (int i = 0; i < NUM_EXT_FWD; i++) begin
          if (ext_num == i) operand = sel.late ? ext_late[i] : ext_bus[i];
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* rtl/result_writeback.sv */
/*
  Result writeback
  picks the active lane and registers the result bus
*/
`timescale 1ns/1ps
`default_nettype none

module result_writeback (
  input  wire               clk,
  input  wire               rst,
  input  simd_pkg::dec_t    dec,
  input  simd_pkg::word_t   alu_data,
  input  simd_pkg::word_t   cmp_data,
  input  wire [1:0]         cmp_flags,
  output simd_pkg::result_t result
);

  always_ff @(posedge clk) begin
    if (rst) begin
      result <= '0;
    end else begin
      result.valid <= dec.valid;
      // data holds while idle, flags only live on compare results
      result.flags <= (dec.valid && dec.is_cmp) ? cmp_flags : 2'b00;
      if (dec.valid) result.data <= dec.is_cmp ? cmp_data : alu_data;
    end
  end

endmodule

`default_nettype wire

/* rtl/simd_cmp.sv */
/*
  Packed compare lane
  equal / signed greater-than element masks plus any/all flags
*/
`timescale 1ns/1ps
`default_nettype none

module simd_cmp (
  input  simd_pkg::dec_t  dec,
  input  simd_pkg::word_t a,
  input  simd_pkg::word_t b,
  output simd_pkg::word_t data,
  output logic [1:0]      flags
);

  logic [3:0] hit16;
  logic [1:0] hit32;
  logic       is_gt;

  assign is_gt = (dec.op == simd_pkg::OP_CMPGT);

  // per-element outcomes for both sizes
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      hit16[i] = is_gt ? ($signed(a[16*i +: 16]) > $signed(b[16*i +: 16]))
                       : (a[16*i +: 16] == b[16*i +: 16]);
    end
    for (int j = 0; j < 2; j++) begin
      hit32[j] = is_gt ? ($signed(a[32*j +: 32]) > $signed(b[32*j +: 32]))
                       : (a[32*j +: 32] == b[32*j +: 32]);
    end
  end

  always_comb begin
    flags = '0;
    if (dec.size == simd_pkg::ELEM_32) begin
      data = {{32{hit32[1]}}, {32{hit32[0]}}};
      flags[simd_pkg::FLAG_ANY] = |hit32;
      flags[simd_pkg::FLAG_ALL] = &hit32;
    end else begin
      data = {{16{hit16[3]}}, {16{hit16[2]}}, {16{hit16[1]}}, {16{hit16[0]}}};
      flags[simd_pkg::FLAG_ANY] = |hit16;
      flags[simd_pkg::FLAG_ALL] = &hit16;
    end
  end

endmodule

`default_nettype wire

/* rtl/simd_exec_unit.sv */
/*
  Packed SIMD execution unit
  operand bypass, issue register, integer and compare lanes, result bus
*/
`timescale 1ns/1ps
`default_nettype none

module simd_exec_unit #(
  parameter int NUM_EXT_FWD = 2
) (
  input  wire               clk,
  input  wire               rst,
  input  simd_pkg::issue_t  issue,
  input  simd_pkg::word_t   ext_bus [NUM_EXT_FWD],
  output simd_pkg::result_t result
);

  simd_pkg::word_t opnd_a;
  simd_pkg::word_t opnd_b;
  simd_pkg::dec_t  dec;
  simd_pkg::word_t op_a;
  simd_pkg::word_t op_b;
  simd_pkg::word_t alu_data;
  simd_pkg::word_t cmp_data;
  logic [1:0]      cmp_flags;

  operand_forward #(
    .NUM_EXT_FWD(NUM_EXT_FWD)
  ) fwd_a (
    .clk     (clk),
    .rst     (rst),
    .sel     (issue.a_sel),
    .reg_val (issue.a),
    .self_bus(result.data),
    .ext_bus (ext_bus),
    .operand (opnd_a)
  );

  operand_forward #(
    .NUM_EXT_FWD(NUM_EXT_FWD)
  ) fwd_b (
    .clk     (clk),
    .rst     (rst),
    .sel     (issue.b_sel),
    .reg_val (issue.b),
    .self_bus(result.data),
    .ext_bus (ext_bus),
    .operand (opnd_b)
  );

  issue_stage i_issue_stage (
    .clk  (clk),
    .rst  (rst),
    .issue(issue),
    .fwd_a(opnd_a),
    .fwd_b(opnd_b),
    .dec  (dec),
    .op_a (op_a),
    .op_b (op_b)
  );

  simd_int_alu i_int_alu (
    .dec (dec),
    .a   (op_a),
    .b   (op_b),
    .data(alu_data)
  );

  simd_cmp i_cmp (
    .dec  (dec),
    .a    (op_a),
    .b    (op_b),
    .data (cmp_data),
    .flags(cmp_flags)
  );

  result_writeback i_writeback (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec),
    .alu_data (alu_data),
    .cmp_data (cmp_data),
    .cmp_flags(cmp_flags),
    .result   (result)
  );

endmodule

`default_nettype wire

/* rtl/simd_int_alu.sv */
/*
  Packed integer lane
  element-wise add, sub, signed min/max and 32-bit half permutes
*/
`timescale 1ns/1ps
`default_nettype none

module simd_int_alu (
  input  simd_pkg::dec_t  dec,
  input  simd_pkg::word_t a,
  input  simd_pkg::word_t b,
  output simd_pkg::word_t data
);

  localparam int HW = simd_pkg::HALF_W;
  localparam int W  = simd_pkg::WORD_W;

  simd_pkg::word_t res16;
  simd_pkg::word_t res32;

  // operands arrive sign extended, so min/max work for both sizes
  function automatic logic [HW-1:0] elem_op(input simd_pkg::opcode_e op,
                                            input logic signed [HW-1:0] x,
                                            input logic signed [HW-1:0] y);
    case (op)
      simd_pkg::OP_ADD: elem_op = x + y;
      simd_pkg::OP_SUB: elem_op = x - y;
      simd_pkg::OP_MIN: elem_op = (x < y) ? x : y;
      default:          elem_op = (x > y) ? x : y;
    endcase
  endfunction

  always_comb begin
    logic [HW-1:0] t;
    t = '0;
    // keep only the low 16 bits, no carry leaks into the neighbour
    for (int i = 0; i < 4; i++) begin
      t = elem_op(dec.op, {{16{a[16*i+15]}}, a[16*i +: 16]},
                  {{16{b[16*i+15]}}, b[16*i +: 16]});
      res16[16*i +: 16] = t[15:0];
    end
    for (int j = 0; j < 2; j++) begin
      res32[HW*j +: HW] = elem_op(dec.op, a[HW*j +: HW], b[HW*j +: HW]);
    end
  end

  always_comb begin
    case (dec.op)
      simd_pkg::OP_SWAP:   data = {a[HW-1:0], a[W-1:HW]};
      simd_pkg::OP_DUP_LO: data = {a[HW-1:0], a[HW-1:0]};
      simd_pkg::OP_DUP_HI: data = {a[W-1:HW], a[W-1:HW]};
      default:             data = (dec.size == simd_pkg::ELEM_32) ? res32 : res16;
    endcase
  end

endmodule

`default_nettype wire

/* rtl/simd_pkg.sv */
/*
  SIMD execution lane shared types
  word, opcode, operand-source, issue, decoded-op and result definitions
*/
`default_nettype none

package simd_pkg;

  localparam int WORD_W = 64;
  localparam int HALF_W = WORD_W / 2;

  // bit positions inside result flags
  localparam int FLAG_ANY = 1;
  localparam int FLAG_ALL = 0;

  typedef logic [WORD_W-1:0] word_t;

  typedef enum logic [3:0] {
    OP_ADD    = 4'd0,
    OP_SUB    = 4'd1,
    OP_MIN    = 4'd2,
    OP_MAX    = 4'd3,
    OP_SWAP   = 4'd4,
    OP_DUP_LO = 4'd5,
    OP_DUP_HI = 4'd6,
    OP_CMPEQ  = 4'd7,
    OP_CMPGT  = 4'd8
  } opcode_e;

  // four 16-bit or two 32-bit elements
  typedef enum logic {
    ELEM_16 = 1'b0,
    ELEM_32 = 1'b1
  } elem_e;

  typedef enum logic [1:0] {
    SRC_REG  = 2'd0,
    SRC_SELF = 2'd1,
    SRC_EXT0 = 2'd2,
    SRC_EXT1 = 2'd3
  } src_e;

  typedef struct packed {
    src_e src;
    logic late;
  } fwd_sel_t;

  typedef struct packed {
    logic     valid;
    opcode_e  op;
    elem_e    size;
    fwd_sel_t a_sel;
    fwd_sel_t b_sel;
    word_t    a;
    word_t    b;
  } issue_t;

  typedef struct packed {
    logic    valid;
    logic    is_cmp;
    opcode_e op;
    elem_e   size;
  } dec_t;

  typedef struct packed {
    logic       valid;
    word_t      data;
    logic [1:0] flags;
  } result_t;

endpackage

`default_nettype wire

/* tb.f */
rtl/simd_pkg.sv
rtl/operand_forward.sv
rtl/issue_stage.sv
rtl/simd_int_alu.sv
rtl/simd_cmp.sv
rtl/result_writeback.sv
rtl/simd_exec_unit.sv
tb/simd_exec_unit_asserts.sv
tb/tb_simd_exec_unit.sv

/* tb/simd_exec_unit_asserts.sv */
/*
  Bound checks on result-bus timing and flag rules
*/
`timescale 1ns/1ps
`default_nettype none

module simd_exec_unit_asserts (
  input wire               clk,
  input wire               rst,
  input simd_pkg::issue_t  issue,
  input simd_pkg::result_t result
);

  // result.valid follows issue.valid two edges later
  a_valid_latency: assert property (@(posedge clk) disable iff (rst)
    !$past(rst) && !$past(rst, 2) |-> result.valid == $past(issue.valid, 2))
    else $error("result valid does not match the issue two cycles earlier");

  a_flags_idle: assert property (@(posedge clk) disable iff (rst)
    !result.valid |-> result.flags == 2'b00)
    else $error("flags set without a valid result");

  a_idle_after_reset: assert property (@(posedge clk) $past(rst) && !rst |-> !result.valid)
    else $error("result valid high right after reset");

endmodule

bind simd_exec_unit simd_exec_unit_asserts i_asserts (
  .clk   (clk),
  .rst   (rst),
  .issue (issue),
  .result(result)
);

`default_nettype wire

/* tb/tb_simd_exec_unit.sv */
/*
  Testbench for the packed SIMD execution unit
  table-driven issues with result-bus checks, random filler rows and a watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_simd_exec_unit;

  typedef struct packed {
    simd_pkg::issue_t  iss;
    simd_pkg::word_t   ext0;
    simd_pkg::word_t   ext1;
    simd_pkg::result_t exp;
  } step_t;

  // operand source codes as {src, late}
  localparam simd_pkg::fwd_sel_t R   = 3'b000;
  localparam simd_pkg::fwd_sel_t S   = 3'b010;
  localparam simd_pkg::fwd_sel_t SL  = 3'b011;
  localparam simd_pkg::fwd_sel_t E0  = 3'b100;
  localparam simd_pkg::fwd_sel_t E0L = 3'b101;
  localparam simd_pkg::fwd_sel_t E1  = 3'b110;
  localparam simd_pkg::fwd_sel_t E1L = 3'b111;

  logic              clk;
  logic              rst;
  simd_pkg::issue_t  issue;
  simd_pkg::word_t   ext_bus [2];
  simd_pkg::result_t result;
  step_t             tab [$];
  simd_pkg::word_t   ext0_now;
  simd_pkg::word_t   ext1_now;
  simd_pkg::word_t   last_data = '0;
  integer            seed = 32'h0bd7a627;
  int                errors = 0;
  logic              built = 1'b0;

  simd_exec_unit #(
    .NUM_EXT_FWD(2)
  ) i_simd_exec_unit (
    .clk    (clk),
    .rst    (rst),
    .issue  (issue),
    .ext_bus(ext_bus),
    .result (result)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // size 1 selects 32-bit elements
  task automatic step(input simd_pkg::opcode_e op, input logic size,
                      input simd_pkg::fwd_sel_t a_sel, input simd_pkg::fwd_sel_t b_sel,
                      input simd_pkg::word_t a, input simd_pkg::word_t b,
                      input simd_pkg::word_t exp_data, input logic [1:0] exp_flags);
    step_t s;
    s = '0;
    s.iss = {1'b1, op, simd_pkg::elem_e'(size), a_sel, b_sel, a, b};
    s.ext0 = ext0_now;
    s.ext1 = ext1_now;
    s.exp = {1'b1, exp_data, exp_flags};
    tab.push_back(s);
    last_data = exp_data;
  endtask

  // result bus keeps the last data while idle
  task automatic idle();
    step_t s;
    s = '0;
    s.ext0 = ext0_now;
    s.ext1 = ext1_now;
    s.exp.data = last_data;
    tab.push_back(s);
  endtask

  // packed 16-bit add of random words
  task automatic filler();
    simd_pkg::word_t a;
    simd_pkg::word_t b;
    simd_pkg::word_t sum;
    a = {$random(seed), $random(seed)};
    b = {$random(seed), $random(seed)};
    for (int i = 0; i < 4; i++) begin
      sum[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
    end
    step(simd_pkg::OP_ADD, 1'b0, R, R, a, b, sum, 2'b00);
  endtask

  task automatic check(input int n);
    step_t s;
    string name;
    s = tab[n];
    name = $sformatf("row %0d op %0d", n, s.iss.op);
    assert (result.valid === s.exp.valid) else begin
      $display("[ERROR] %s valid: expected %0b, actual %0b", name, s.exp.valid, result.valid);
      errors++;
    end
    assert (result.data === s.exp.data) else begin
      $display("[ERROR] %s data: expected %h, actual %h", name, s.exp.data, result.data);
      errors++;
    end
    assert (result.flags === s.exp.flags) else begin
      $display("[ERROR] %s flags: expected %b, actual %b", name, s.exp.flags, result.flags);
      errors++;
    end
  endtask

  initial begin
    wait (built);
    #((tab.size() + 20) * 8);
    $display("watchdog timed out before all rows were checked");
    $display("Regression failed");
    $finish;
  end

  initial begin
    rst = 1'b1;
    issue = '0;
    ext_bus[0] = '0;
    ext_bus[1] = '0;
    ext0_now = '0;
    ext1_now = '0;
    idle();
    idle();
    step(simd_pkg::OP_ADD, 1'b0, R, R, 64'h0001_ffff_7fff_0005, 64'h0001_0001_0001_0003,
         64'h0002_0000_8000_0008, 2'b00);
    step(simd_pkg::OP_ADD, 1'b1, R, R, 64'h0000_0001_ffff_ffff, 64'h0000_0001_0000_0001,
         64'h0000_0002_0000_0000, 2'b00);
    step(simd_pkg::OP_SUB, 1'b0, R, R, 64'h0000_0005_0010_0000, 64'h0001_0005_0001_0001,
         64'hffff_0000_000f_ffff, 2'b00);
    step(simd_pkg::OP_SUB, 1'b1, R, R, 64'h0000_0005_0000_0003, 64'h0000_0001_0000_0004,
         64'h0000_0004_ffff_ffff, 2'b00);
    step(simd_pkg::OP_MIN, 1'b0, R, R, 64'h8000_0005_fff0_0001, 64'h7fff_fffb_0010_0002,
         64'h8000_fffb_fff0_0001, 2'b00);
    step(simd_pkg::OP_MAX, 1'b1, R, R, 64'hffff_fffe_0000_0010, 64'h0000_0001_8000_0000,
         64'h0000_0001_0000_0010, 2'b00);
    step(simd_pkg::OP_SWAP, 1'b0, R, R, 64'h1111_2222_3333_4444, '0,
         64'h3333_4444_1111_2222, 2'b00);
    step(simd_pkg::OP_DUP_LO, 1'b0, R, R, 64'haaaa_bbbb_cccc_dddd, '0,
         64'hcccc_dddd_cccc_dddd, 2'b00);
    step(simd_pkg::OP_DUP_HI, 1'b0, R, R, 64'haaaa_bbbb_cccc_dddd, '0,
         64'haaaa_bbbb_aaaa_bbbb, 2'b00);
    step(simd_pkg::OP_CMPEQ, 1'b0, R, R, 64'h0001_0002_0003_0004, 64'h0001_0000_0003_0000,
         64'hffff_0000_ffff_0000, 2'b10);
    step(simd_pkg::OP_CMPEQ, 1'b1, R, R, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0,
         64'hffff_ffff_ffff_ffff, 2'b11);
    step(simd_pkg::OP_CMPGT, 1'b0, R, R, 64'h8000_0000_0001_fffe, 64'h7fff_0000_0002_ffff,
         64'h0000_0000_0000_0000, 2'b00);
    step(simd_pkg::OP_CMPGT, 1'b1, R, R, 64'h0000_0001_ffff_ffff, 64'hffff_ffff_0000_0000,
         64'hffff_ffff_0000_0000, 2'b10);
    // external buses change every row so late differs from current
    ext0_now = 64'h0000_0010_0000_0020;
    ext1_now = 64'h0000_0001_0000_0002;
    step(simd_pkg::OP_ADD, 1'b1, E0, E1, '0, '0, 64'h0000_0011_0000_0022, 2'b00);
    ext0_now = 64'h0000_0100_0000_0200;
    ext1_now = 64'h0000_0003_0000_0004;
    step(simd_pkg::OP_SUB, 1'b1, E0, E1L, '0, '0, 64'h0000_00ff_0000_01fe, 2'b00);
    ext0_now = '0;
    ext1_now = '0;
    step(simd_pkg::OP_ADD, 1'b1, E0L, E1L, '0, '0, 64'h0000_0103_0000_0204, 2'b00);
    // own result chain
    step(simd_pkg::OP_SWAP, 1'b0, R, R, 64'h0000_0001_0000_0002, '0,
         64'h0000_0002_0000_0001, 2'b00);
    idle();
    step(simd_pkg::OP_ADD, 1'b1, S, R, '0, 64'h0000_0010_0000_0010,
         64'h0000_0012_0000_0011, 2'b00);
    step(simd_pkg::OP_ADD, 1'b1, SL, S, '0, '0, 64'h0000_0004_0000_0002, 2'b00);
    step(simd_pkg::OP_ADD, 1'b1, S, SL, '0, '0, 64'h0000_0014_0000_0012, 2'b00);
    repeat (6) filler();
    built = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    for (int n = 0; n < tab.size() + 2; n++) begin
      @(negedge clk);
      if (n >= 2) check(n - 2);
      if (n < tab.size()) begin
        issue = tab[n].iss;
        ext_bus[0] = tab[n].ext0;
        ext_bus[1] = tab[n].ext1;
      end else begin
        issue = '0;
      end
    end
    $display("checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
